// ==== tb.f ====
verilog/esc_pkg.sv
verilog/alert_intake.sv
verilog/alert_accu.sv
verilog/esc_timer.sv
verilog/esc_top.sv
bench/tb_esc.sv

// ==== Bender.yml ====
package:
  name: esc_block

sources:
  # design
  - files:
      - verilog/esc_pkg.sv
      - verilog/alert_intake.sv
      - verilog/alert_accu.sv
      - verilog/esc_timer.sv
      - verilog/esc_top.sv
  # testbench
  - target: simulation
    files:
      - bench/tb_esc.sv

// ==== bench/tb_esc.sv ====
// escalation block testbench
// directed tests for threshold trigger, phase walk, interrupt timeout,
// clear with back-pressure, accumulator overflow and disable

`timescale 1ns/1ps
`default_nettype none

module tb_esc;

  //////////////////////////////
  // timing constants
  //////////////////////////////

  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DLY    = 1;
  localparam int RESET_CYCLES = 10;
  // rough length of each test in cycles including reset
  localparam int THRESH_LEN   = RESET_CYCLES + 20;
  localparam int WALK_LEN     = 3 * (RESET_CYCLES + 4 * 8 + 8);
  localparam int TIMEOUT_LEN  = 2 * (RESET_CYCLES + 15);
  localparam int CLEAR_LEN    = RESET_CYCLES + 30;
  localparam int OVFL_LEN     = RESET_CYCLES + 2 * 64 + 20;
  localparam int DISABLE_LEN  = RESET_CYCLES + 30;
  localparam int TEST_CYCLES  = THRESH_LEN + WALK_LEN + TIMEOUT_LEN + CLEAR_LEN
                                + OVFL_LEN + DISABLE_LEN;
  // generous margin on top of the expected run
  localparam int WATCHDOG_CYCLES = 8 * TEST_CYCLES;

  logic clk;
  logic reset_i;
  logic alert_valid_i;
  logic alert_ready_o;
  logic en_i;
  logic clr_i;
  logic [esc_pkg::AccuCntDw-1:0]                        accu_thresh_i;
  logic                                                 timeout_en_i;
  logic [esc_pkg::EscCntDw-1:0]                         timeout_cyc_i;
  logic [esc_pkg::N_ESC_SEV-1:0]                        esc_en_i;
  logic [esc_pkg::N_ESC_SEV-1:0][esc_pkg::PHASE_DW-1:0] esc_map_i;
  logic [esc_pkg::N_PHASES-1:0][esc_pkg::EscCntDw-1:0]  phase_cyc_i;
  logic [esc_pkg::PHASE_DW-1:0]                         crashdump_phase_i;
  logic [esc_pkg::AccuCntDw-1:0]                        accu_cnt_o;
  logic                                                 latch_crashdump_o;
  logic                                                 esc_trig_o;
  logic [esc_pkg::EscCntDw-1:0]                         esc_cnt_o;
  logic [esc_pkg::N_ESC_SEV-1:0]                        esc_sig_req_o;
  esc_pkg::cstate_e                                     esc_state_o;

  integer seed = 32'hd2a9;

  //////////////////////////////
  // clock and DUT
  //////////////////////////////

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  esc_top u_esc_top (
    .clk_i             (clk),
    .reset_i           (reset_i),
    .alert_valid_i     (alert_valid_i),
    .alert_ready_o     (alert_ready_o),
    .en_i              (en_i),
    .clr_i             (clr_i),
    .accu_thresh_i     (accu_thresh_i),
    .timeout_en_i      (timeout_en_i),
    .timeout_cyc_i     (timeout_cyc_i),
    .esc_en_i          (esc_en_i),
    .esc_map_i         (esc_map_i),
    .phase_cyc_i       (phase_cyc_i),
    .crashdump_phase_i (crashdump_phase_i),
    .accu_cnt_o        (accu_cnt_o),
    .latch_crashdump_o (latch_crashdump_o),
    .esc_trig_o        (esc_trig_o),
    .esc_cnt_o         (esc_cnt_o),
    .esc_sig_req_o     (esc_sig_req_o),
    .esc_state_o       (esc_state_o)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first error");
    end
  endtask

  // quiet configuration with signal k mapped to phase k and no timeout
  task automatic set_defaults;
    alert_valid_i     = 1'b0;
    en_i              = 1'b1;
    clr_i             = 1'b0;
    accu_thresh_i     = 6'd3;
    timeout_en_i      = 1'b0;
    timeout_cyc_i     = 16'd5;
    esc_en_i          = 4'hf;
    esc_map_i         = {2'd3, 2'd2, 2'd1, 2'd0};
    phase_cyc_i       = {16'd4, 16'd4, 16'd4, 16'd4};
    crashdump_phase_i = 2'd0;
  endtask

  // returns one drive delay after the edge that releases reset
  task automatic apply_reset;
    set_defaults;
    reset_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    reset_i = 1'b0;
  endtask

  // hold valid until the intake takes it and return just after that edge
  task automatic send_alert;
    alert_valid_i = 1'b1;
    @(negedge clk);
    while (!alert_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
    alert_valid_i = 1'b0;
  endtask

  // enabled signals whose mapped phase is the given one
  function automatic logic [3:0] expected_sig(input int phase);
    logic [3:0] sig;
    sig = '0;
    for (int j = 0; j < esc_pkg::N_ESC_SEV; j++) begin
      sig[j] = esc_en_i[j] && (esc_map_i[j] == phase);
    end
    return sig;
  endfunction

  // phase states carry the msb and the index in the low bits
  function automatic logic [2:0] phase_state(input int k);
    return {1'b1, k[1:0]};
  endfunction

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic threshold_trigger;
    apply_reset;
    accu_thresh_i = 6'd3;
    repeat (3) send_alert;
    // last alert is consumed one edge after acceptance
    repeat (2) @(negedge clk);
    check_value(esc_state_o, esc_pkg::Idle, "state after thresh alerts");
    check_value(accu_cnt_o, 3, "count after thresh alerts");
    @(posedge clk);
    #DRIVE_DLY;
    send_alert;
    @(negedge clk);
    check_value(esc_trig_o, 1'b1, "trigger on alert thresh+1");
    check_value(esc_state_o, esc_pkg::Idle, "state in trigger cycle");
    @(negedge clk);
    check_value(esc_state_o, esc_pkg::Phase0, "state after trigger");
    check_value(accu_cnt_o, 4, "count after trigger");
  endtask

  task automatic phase_walk(input int iter);
    int len;
    apply_reset;
    for (int k = 0; k < esc_pkg::N_PHASES; k++) begin
      phase_cyc_i[k] = 16'(({$random(seed)} % 8) + 1);
    end
    // zero length phase still lasts one cycle
    if (iter == 0) begin
      phase_cyc_i[2] = '0;
    end
    esc_map_i         = 8'($random(seed));
    esc_en_i          = 4'($random(seed));
    crashdump_phase_i = 2'($random(seed));
    accu_thresh_i     = 6'd0;
    send_alert;
    @(negedge clk);
    check_value(esc_trig_o, 1'b1, "walk trigger");
    for (int k = 0; k < esc_pkg::N_PHASES; k++) begin
      len = (phase_cyc_i[k] == 0) ? 1 : int'(phase_cyc_i[k]);
      // counter starts at 1 on phase entry
      for (int j = 1; j <= len; j++) begin
        @(negedge clk);
        check_value(esc_state_o, phase_state(k), $sformatf("state in phase %0d", k));
        check_value(esc_cnt_o, j, $sformatf("counter in phase %0d", k));
        check_value(esc_sig_req_o, expected_sig(k), $sformatf("signals in phase %0d", k));
        check_value(latch_crashdump_o, (k == crashdump_phase_i),
                    $sformatf("crash dump in phase %0d", k));
      end
    end
    @(negedge clk);
    check_value(esc_state_o, esc_pkg::Terminal, "state after phase 3");
    check_value(esc_sig_req_o, 4'h0, "signals in terminal");
    check_value(latch_crashdump_o, 1'b0, "crash dump in terminal");
  endtask

  task automatic interrupt_timeout;
    apply_reset;
    timeout_cyc_i = 16'd5;
    timeout_en_i  = 1'b1;
    @(negedge clk);
    check_value(esc_state_o, esc_pkg::Idle, "state before timeout");
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_value(esc_state_o, esc_pkg::Timeout, "state while timing out");
      check_value(esc_trig_o, (i == 4), "trigger at timeout expiry");
    end
    @(negedge clk);
    check_value(esc_state_o, esc_pkg::Phase0, "state after timeout");

    // early drop of the timeout enable
    apply_reset;
    timeout_cyc_i = 16'd5;
    timeout_en_i  = 1'b1;
    repeat (3) @(negedge clk);
    check_value(esc_state_o, esc_pkg::Timeout, "state before drop");
    @(posedge clk);
    #DRIVE_DLY;
    timeout_en_i = 1'b0;
    @(negedge clk);
    check_value(esc_state_o, esc_pkg::Timeout, "state in drop cycle");
    repeat (4) begin
      @(negedge clk);
      check_value(esc_state_o, esc_pkg::Idle, "state after drop");
    end
  endtask

  task automatic clear_backpressure;
    apply_reset;
    accu_thresh_i = 6'd0;
    phase_cyc_i   = {16'd8, 16'd8, 16'd8, 16'd8};
    send_alert;
    @(negedge clk);
    check_value(esc_trig_o, 1'b1, "clear test trigger");
    repeat (10) @(negedge clk);
    check_value(esc_state_o, esc_pkg::Phase1, "state before clear");
    @(posedge clk);
    #DRIVE_DLY;
    clr_i         = 1'b1;
    alert_valid_i = 1'b1;
    // intake is empty, so one alert still goes in
    @(negedge clk);
    check_value(alert_ready_o, 1'b1, "ready on first clear cycle");
    check_value(accu_cnt_o, 1, "count before clear");
    @(posedge clk);
    #DRIVE_DLY;
    alert_valid_i = 1'b0;
    @(negedge clk);
    check_value(esc_state_o, esc_pkg::Idle, "state after clear");
    check_value(accu_cnt_o, 0, "count after clear");
    check_value(alert_ready_o, 1'b0, "ready with held alert");
    repeat (4) begin
      @(negedge clk);
      check_value(alert_ready_o, 1'b0, "ready while clearing");
      check_value(accu_cnt_o, 0, "count while clearing");
      check_value(esc_state_o, esc_pkg::Idle, "state while clearing");
    end
    // raise the threshold so the held alert does not re-trigger
    @(posedge clk);
    #DRIVE_DLY;
    clr_i         = 1'b0;
    accu_thresh_i = 6'd5;
    @(negedge clk);
    check_value(accu_cnt_o, 0, "count in drain cycle");
    @(negedge clk);
    check_value(accu_cnt_o, 1, "count after clear drops");
    check_value(alert_ready_o, 1'b1, "ready after drain");
    check_value(esc_state_o, esc_pkg::Idle, "state after drain");
  endtask

  task automatic overflow_error;
    int waited;
    apply_reset;
    accu_thresh_i = 6'd63;
    repeat (63) send_alert;
    repeat (2) @(negedge clk);
    check_value(accu_cnt_o, 63, "count at saturation");
    check_value(esc_state_o, esc_pkg::Idle, "state at saturation");
    @(posedge clk);
    #DRIVE_DLY;
    send_alert;
    // overflow may pass through phase 0 on the way
    waited = 0;
    while (esc_state_o != esc_pkg::FsmError && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    check_value(esc_state_o, esc_pkg::FsmError, "state after overflow");
    check_value(esc_sig_req_o, 4'hf, "signals in error");
    check_value(accu_cnt_o, 63, "count stays saturated");
    @(posedge clk);
    #DRIVE_DLY;
    clr_i = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_value(esc_state_o, esc_pkg::FsmError, "error state during clear");
      check_value(esc_sig_req_o, 4'hf, "signals during clear");
    end
    @(posedge clk);
    #DRIVE_DLY;
    clr_i = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_value(esc_state_o, esc_pkg::FsmError, "error state after clear");
      check_value(esc_sig_req_o, 4'hf, "signals after clear");
    end
  endtask

  task automatic disable_block;
    apply_reset;
    en_i          = 1'b0;
    accu_thresh_i = 6'd1;
    timeout_en_i  = 1'b1;
    timeout_cyc_i = 16'd3;
    repeat (4) send_alert;
    repeat (20) begin
      @(negedge clk);
      check_value(esc_state_o, esc_pkg::Idle, "state while disabled");
      check_value(esc_trig_o, 1'b0, "trigger while disabled");
      check_value(esc_sig_req_o, 4'h0, "signals while disabled");
    end
    check_value(accu_cnt_o, 4, "count while disabled");
  endtask

  //////////////////////////////
  // watchdog and sequence
  //////////////////////////////

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("error: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset_i = 1'b1;
    set_defaults;
    threshold_trigger;
    for (int i = 0; i < 3; i++) begin
      phase_walk(i);
    end
    interrupt_timeout;
    clear_backpressure;
    overflow_error;
    disable_block;
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/esc_top.sv ====
// escalation top level
// chains the alert intake stage, the accumulator and the escalation
// timer into one single-class escalation block

`timescale 1ns/1ps
`default_nettype none

module esc_top (
  input  wire                                                 clk_i,
  input  wire                                                 reset_i,
  // alert event port
  input  wire                                                 alert_valid_i,
  output logic                                                alert_ready_o,
  // configuration
  input  wire                                                 en_i,
  input  wire                                                 clr_i,
  input  wire  [esc_pkg::AccuCntDw-1:0]                       accu_thresh_i,
  input  wire                                                 timeout_en_i,
  input  wire  [esc_pkg::EscCntDw-1:0]                        timeout_cyc_i,
  input  wire  [esc_pkg::N_ESC_SEV-1:0]                       esc_en_i,
  input  wire  [esc_pkg::N_ESC_SEV-1:0][esc_pkg::PHASE_DW-1:0] esc_map_i,
  input  wire  [esc_pkg::N_PHASES-1:0][esc_pkg::EscCntDw-1:0]  phase_cyc_i,
  input  wire  [esc_pkg::PHASE_DW-1:0]                        crashdump_phase_i,
  // status and escalation outputs
  output logic [esc_pkg::AccuCntDw-1:0]                       accu_cnt_o,
  output logic                                                latch_crashdump_o,
  output logic                                                esc_trig_o,
  output logic [esc_pkg::EscCntDw-1:0]                        esc_cnt_o,
  output logic [esc_pkg::N_ESC_SEV-1:0]                       esc_sig_req_o,
  output esc_pkg::cstate_e                                    esc_state_o
);

  // intake to accumulator
  logic intake_valid;
  logic accu_ready;
  // accumulator to timer
  logic accu_trig;
  logic accu_fail;

  //////////////////////////////
  // pipeline stages
  //////////////////////////////

  alert_intake u_intake (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .alert_valid_i  (alert_valid_i),
    .alert_ready_o  (alert_ready_o),
    .accu_ready_i   (accu_ready),
    .intake_valid_o (intake_valid)
  );

  alert_accu u_accu (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .clr_i          (clr_i),
    .intake_valid_i (intake_valid),
    .accu_ready_o   (accu_ready),
    .accu_thresh_i  (accu_thresh_i),
    .accu_cnt_o     (accu_cnt_o),
    .accu_trig_o    (accu_trig),
    .accu_fail_o    (accu_fail)
  );

  esc_timer u_timer (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .en_i              (en_i),
    .clr_i             (clr_i),
    .accu_trig_i       (accu_trig),
    .accu_fail_i       (accu_fail),
    .timeout_en_i      (timeout_en_i),
    .timeout_cyc_i     (timeout_cyc_i),
    .esc_en_i          (esc_en_i),
    .esc_map_i         (esc_map_i),
    .phase_cyc_i       (phase_cyc_i),
    .crashdump_phase_i (crashdump_phase_i),
    .latch_crashdump_o (latch_crashdump_o),
    .esc_trig_o        (esc_trig_o),
    .esc_cnt_o         (esc_cnt_o),
    .esc_sig_req_o     (esc_sig_req_o),
    .esc_state_o       (esc_state_o)
  );

endmodule

`default_nettype wire

// ==== verilog/esc_timer.sv ====
// escalation timer
// walks through four timed escalation phases once triggered by the
// accumulator or by an expired interrupt timeout. the phase counter is
// shared with the timeout. each phase asserts the escalation signals
// mapped to it, and an accumulator overflow locks the FSM in an error
// state with every escalation signal asserted.

`timescale 1ns/1ps
`default_nettype none

module esc_timer (
  input  wire                                                 clk_i,
  input  wire                                                 reset_i,
  // enables timeout and escalation
  input  wire                                                 en_i,
  // aborts escalation
  input  wire                                                 clr_i,
  input  wire                                                 accu_trig_i,
  input  wire                                                 accu_fail_i,
  input  wire                                                 timeout_en_i,
  input  wire  [esc_pkg::EscCntDw-1:0]                        timeout_cyc_i,
  input  wire  [esc_pkg::N_ESC_SEV-1:0]                       esc_en_i,
  // phase each escalation signal belongs to
  input  wire  [esc_pkg::N_ESC_SEV-1:0][esc_pkg::PHASE_DW-1:0] esc_map_i,
  input  wire  [esc_pkg::N_PHASES-1:0][esc_pkg::EscCntDw-1:0]  phase_cyc_i,
  input  wire  [esc_pkg::PHASE_DW-1:0]                        crashdump_phase_i,
  output logic                                                latch_crashdump_o,
  output logic                                                esc_trig_o,
  output logic [esc_pkg::EscCntDw-1:0]                        esc_cnt_o,
  output logic [esc_pkg::N_ESC_SEV-1:0]                       esc_sig_req_o,
  output esc_pkg::cstate_e                                    esc_state_o
);

  esc_pkg::cstate_e state_d, state_q;

  logic [esc_pkg::EscCntDw-1:0] cnt_q;
  logic [esc_pkg::EscCntDw-1:0] thresh;
  logic                         cnt_en;
  logic                         cnt_clr;
  logic                         cnt_ge;
  logic                         in_phase;
  logic                         fsm_error;
  logic                         esc_start;
  logic [esc_pkg::PHASE_DW-1:0] phase_idx;
  logic [esc_pkg::N_PHASES-1:0] phase_oh;

  //////////////////////////////
  // phase decode
  //////////////////////////////

  // msb of the state marks a phase, the lsbs are its index
  assign in_phase  = state_q[2];
  assign phase_idx = state_q[esc_pkg::PHASE_DW-1:0];
  assign phase_oh  = in_phase ? (esc_pkg::N_PHASES'(1) << phase_idx) : '0;

  // crash dump request held for the selected phase
  assign latch_crashdump_o = in_phase & (phase_idx == crashdump_phase_i);

  // threshold picked by state, timeout count outside the phases
  assign thresh = in_phase ? phase_cyc_i[phase_idx] : timeout_cyc_i;
  assign cnt_ge = (cnt_q >= thresh);

  // an accumulator trigger only counts when enabled and not clearing
  assign esc_start = accu_trig_i & en_i & ~clr_i;

  //////////////////////////////
  // main FSM
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    cnt_en     = 1'b0;
    cnt_clr    = 1'b0;
    esc_trig_o = 1'b0;
    fsm_error  = 1'b0;

    unique case (state_q)
      // counter rests at zero here, so a zero timeout gives cnt_ge
      esc_pkg::Idle: begin
        cnt_clr = 1'b1;
        if (esc_start) begin
          state_d    = esc_pkg::Phase0;
          cnt_en     = 1'b1;
          esc_trig_o = 1'b1;
        end else if (en_i && timeout_en_i && !cnt_ge && !clr_i) begin
          state_d = esc_pkg::Timeout;
          cnt_en  = 1'b1;
        end
      end

      // interrupt timeout running, trigger takes precedence
      esc_pkg::Timeout: begin
        if (clr_i) begin
          state_d = esc_pkg::Idle;
          cnt_clr = 1'b1;
        end else if (esc_start || (cnt_ge && timeout_en_i)) begin
          state_d    = esc_pkg::Phase0;
          cnt_clr    = 1'b1;
          cnt_en     = 1'b1;
          esc_trig_o = 1'b1;
        end else if (timeout_en_i) begin
          cnt_en = 1'b1;
        end else begin
          // timeout switched off, back to idle
          state_d = esc_pkg::Idle;
          cnt_clr = 1'b1;
        end
      end

      // all four phases share one body, only thresh and index differ
      esc_pkg::Phase0, esc_pkg::Phase1, esc_pkg::Phase2, esc_pkg::Phase3: begin
        cnt_en = 1'b1;
        if (clr_i) begin
          state_d = esc_pkg::Idle;
          cnt_clr = 1'b1;
          cnt_en  = 1'b0;
        end else if (cnt_ge) begin
          cnt_clr = 1'b1;
          if (state_q == esc_pkg::Phase3) begin
            state_d = esc_pkg::Terminal;
            cnt_en  = 1'b0;
          end else begin
            // next phase, counter restarts at 1
            state_d = esc_pkg::cstate_e'(state_q + 3'd1);
          end
        end
      end

      // escalation done, only a clear leaves
      esc_pkg::Terminal: begin
        cnt_clr = 1'b1;
        if (clr_i) begin
          state_d = esc_pkg::Idle;
        end
      end

      // locked until reset, counter holds
      esc_pkg::FsmError: begin
        fsm_error = 1'b1;
      end

      default: begin
        state_d = esc_pkg::FsmError;
      end
    endcase

    // overflow in the accumulator overrides everything
    if (accu_fail_i) begin
      state_d = esc_pkg::FsmError;
    end
  end

  assign esc_state_o = state_q;

  //////////////////////////////
  // escalation signal mapping
  //////////////////////////////

  logic [esc_pkg::N_ESC_SEV-1:0][esc_pkg::N_PHASES-1:0] esc_map_oh;

  for (genvar k = 0; k < esc_pkg::N_ESC_SEV; k++) begin : gen_sig_map
    // one-hot phase of signal k, empty when disabled
    assign esc_map_oh[k] = esc_pkg::N_PHASES'(esc_en_i[k]) << esc_map_i[k];
    assign esc_sig_req_o[k] = (|(esc_map_oh[k] & phase_oh)) | fsm_error;
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= esc_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // clr with en loads 1 on phase entry, clr alone zeroes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (cnt_clr && cnt_en) begin
      cnt_q <= esc_pkg::EscCntDw'(1);
    end else if (cnt_clr) begin
      cnt_q <= '0;
    end else if (cnt_en) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign esc_cnt_o = cnt_q;

endmodule

`default_nettype wire

// ==== verilog/alert_accu.sv ====
// alert accumulator
// counts the alerts taken from the intake stage and saturates at the top
// of the count range. raises the escalation trigger once the stored count
// has reached the programmed threshold, and flags an overflow as a
// sticky failure.

`timescale 1ns/1ps
`default_nettype none

module alert_accu (
  input  wire                             clk_i,
  input  wire                             reset_i,
  input  wire                             clr_i,
  // event from the intake stage
  input  wire                             intake_valid_i,
  output logic                            accu_ready_o,
  // threshold and count
  input  wire  [esc_pkg::AccuCntDw-1:0]   accu_thresh_i,
  output logic [esc_pkg::AccuCntDw-1:0]   accu_cnt_o,
  // towards the timer
  output logic                            accu_trig_o,
  output logic                            accu_fail_o
);

  logic [esc_pkg::AccuCntDw-1:0] accu_cnt_q;
  logic                          fail_q;
  logic                          consume;
  logic                          cnt_max;

  //////////////////////////////
  // consume and trigger
  //////////////////////////////

  // alerts are refused while a clear is in progress
  assign accu_ready_o = ~clr_i;
  assign consume      = intake_valid_i & accu_ready_o;

  // count sits at the top of its range
  assign cnt_max = &accu_cnt_q;

  // compare against the stored count, so alert thresh+1 fires
  assign accu_trig_o = consume & (accu_cnt_q >= accu_thresh_i);

  assign accu_cnt_o  = accu_cnt_q;
  assign accu_fail_o = fail_q;

  //////////////////////////////
  // counter
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      accu_cnt_q <= '0;
    end else if (clr_i) begin
      accu_cnt_q <= '0;
    end else if (consume && !cnt_max) begin
      accu_cnt_q <= accu_cnt_q + 1'b1;
    end
  end

  //////////////////////////////
  // overflow flag
  //////////////////////////////

  // sticky until reset, a clear does not remove it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fail_q <= 1'b0;
    end else if (consume && cnt_max) begin
      fail_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alert_intake.sv ====
// alert intake stage
// one-entry skid register between the alert source and the accumulator.
// the source only sees back-pressure while the accumulator refuses
// to take the pending event.

`timescale 1ns/1ps
`default_nettype none

module alert_intake (
  input  wire  clk_i,
  input  wire  reset_i,
  // source side
  input  wire  alert_valid_i,
  output logic alert_ready_o,
  // accumulator side
  input  wire  accu_ready_i,
  output logic intake_valid_o
);

  //////////////////////////////
  // handshakes
  //////////////////////////////

  // one pending event at most
  logic full_q;
  logic accept;
  logic drain;

  // held event leaves when the accumulator takes it
  assign drain = full_q & accu_ready_i;

  // room when empty, or when the held event drains this cycle
  assign alert_ready_o = ~full_q | accu_ready_i;
  assign accept        = alert_valid_i & alert_ready_o;

  assign intake_valid_o = full_q;

  //////////////////////////////
  // full flag
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      // new event replaces a draining one, or fills the empty slot
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/esc_pkg.sv ====
// escalation package
// shared widths and counts for the alert escalation block, plus the
// state encoding that the timer reports to the outside

`default_nettype none

package esc_pkg;

  //////////////////////////////
  // widths and counts
  //////////////////////////////

  // timer counter, timeout count and phase cycle counts
  localparam int EscCntDw  = 16;
  // accumulator count and threshold, saturates at 63
  localparam int AccuCntDw = 6;
  // number of escalation signals
  localparam int N_ESC_SEV = 4;
  // number of escalation phases
  localparam int N_PHASES  = 4;
  // width of a phase index
  localparam int PHASE_DW  = 2;

  //////////////////////////////
  // reported timer state
  //////////////////////////////

  // msb set means one of the escalation phases,
  // the two lsbs then hold the phase index
  typedef enum logic [2:0] {
    Idle     = 3'b000,
    Timeout  = 3'b001,
    Terminal = 3'b010,
    FsmError = 3'b011,
    Phase0   = 3'b100,
    Phase1   = 3'b101,
    Phase2   = 3'b110,
    Phase3   = 3'b111
  } cstate_e;

endpackage

`default_nettype wire
